//--- ntt_core.f
verilog/ntt_pkg.sv
verilog/ntt_sched_if.sv
verilog/coef_regfile.sv
verilog/twiddle_ram.sv
verilog/mod_mult.sv
verilog/butterfly_unit.sv
verilog/addr_gen.sv
verilog/ntt_core.sv
verification/ntt_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the ntt core testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -j 0 --top-module ntt_tb -f ntt_core.f -o ntt_sim
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "verilator build failed with status $build_status"
    exit 1
fi

./obj_dir/ntt_sim
sim_status=$?
if [ $sim_status -ne 0 ]; then
    echo "simulation failed with status $sim_status"
    exit 1
fi

exit 0

//--- verification/ntt_tb.sv
// testbench for the 16-point ntt core, reference transform and output assertions
`timescale 1ns/1ps

module ntt_tb;
    import ntt_pkg::*;

    localparam int     CLK_PERIOD = 40;
    localparam int     RESET_CYCLES = 10;
    localparam longint MOD = longint'(Q);
    localparam int     TRANSFORMS = 6;
    localparam int     COMPUTE_CYCLES = RING_DEPTH * (HALF_SIZE + PIPE_DELAY);
    localparam int     WATCHDOG_CYCLES =
        TRANSFORMS * (COMPUTE_CYCLES + RING_SIZE + HALF_SIZE + 20) + RESET_CYCLES;

    logic  clk;
    logic  reset;
    logic  load_w;
    logic  load_data;
    logic  start;
    coef_t din;
    logic  done;
    coef_t dout;

    coef_t  tw_vec   [HALF_SIZE];
    coef_t  coef_vec [RING_SIZE];
    coef_t  exp_vec  [RING_SIZE];
    longint root;

    // output window tracking
    bit seen_done   = 1'b0;
    bit out_active  = 1'b0;
    int out_pos     = 0;
    int done_count  = 0;
    int start_count = 0;

    ntt_core dut_i (
        .clk      (clk),
        .reset    (reset),
        .load_w   (load_w),
        .load_data(load_data),
        .start    (start),
        .din      (din),
        .done     (done),
        .dout     (dout)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic flag_error(string msg);
        $display("FAIL %0t: %s", $time, msg);
        $display("Checks failed");
        $fatal(1, "stopping at the first error");
    endtask

    function automatic longint mod_pow(longint base, int e);
        longint r;
        r = 1;
        for (int i = 0; i < e; i++) begin
            r = (r * (base % MOD)) % MOD;
        end
        return r;
    endfunction

    function automatic int bitrev4(int i);
        int r;
        r = 0;
        for (int b = 0; b < RING_DEPTH; b++) begin
            r = (r << 1) | ((i >> b) & 1);
        end
        return r;
    endfunction

    // w^8 = -1 makes w a primitive 16th root
    function automatic longint find_root();
        longint g;
        longint found;
        found = 0;
        for (g = 2; g < MOD && found == 0; g++) begin
            if (mod_pow(g, HALF_SIZE) == MOD - 1) begin
                found = g;
            end
        end
        return found;
    endfunction

    // naive transform, stored in bit-reversed output order
    task automatic compute_expected();
        longint x [RING_SIZE];
        longint acc;
        for (int k = 0; k < RING_SIZE; k++) begin
            acc = 0;
            for (int j = 0; j < RING_SIZE; j++) begin
                acc = (acc + longint'(coef_vec[j]) * mod_pow(root, (j * k) % RING_SIZE)) % MOD;
            end
            x[k] = acc;
        end
        for (int i = 0; i < RING_SIZE; i++) begin
            exp_vec[i] = coef_t'(x[bitrev4(i)]);
        end
    endtask

    task automatic load_twiddles();
        @(posedge clk);
        load_w <= 1'b1;
        for (int i = 0; i < HALF_SIZE; i++) begin
            @(posedge clk);
            load_w <= 1'b0;
            din    <= tw_vec[i];
        end
    endtask

    task automatic load_coefs();
        @(posedge clk);
        load_data <= 1'b1;
        for (int i = 0; i < RING_SIZE; i++) begin
            @(posedge clk);
            load_data <= 1'b0;
            din       <= coef_vec[i];
        end
    endtask

    task automatic pulse_stray(int gap, int which);
        repeat (gap) @(posedge clk);
        case (which)
            0: start <= 1'b1;
            1: load_w <= 1'b1;
            default: load_data <= 1'b1;
        endcase
        din <= coef_t'($urandom % MOD);
        @(posedge clk);
        start     <= 1'b0;
        load_w    <= 1'b0;
        load_data <= 1'b0;
    endtask

    // stray pulses land in COMPUTE and in OUTPUT
    task automatic run_transform(bit with_stray);
        compute_expected();
        @(posedge clk);
        start       <= 1'b1;
        start_count = start_count + 1;
        @(posedge clk);
        start <= 1'b0;
        if (with_stray) begin
            pulse_stray(4, 0);
            pulse_stray(4, 1);
            pulse_stray(4, 2);
        end
        while (done_count < start_count) @(posedge clk);
        if (with_stray) begin
            pulse_stray(2, 0);
            pulse_stray(2, 1);
            pulse_stray(2, 2);
        end
        while (out_active) @(posedge clk);
    endtask

    always @(posedge clk) begin
        if (done) begin
            seen_done  <= 1'b1;
            done_count <= done_count + 1;
            out_active <= 1'b1;
            out_pos    <= 0;
        end else if (out_active) begin
            out_pos <= out_pos + 1;
            if (out_pos == RING_SIZE - 1) begin
                out_active <= 1'b0;
            end
        end
    end

    a_quiet_before_done: assert property (@(posedge clk) disable iff (reset)
        !seen_done |-> (dout == '0))
        else flag_error($sformatf("dout %0d before the first done", $sampled(dout)));

    a_dout_match: assert property (@(posedge clk) disable iff (reset)
        out_active |-> (dout == exp_vec[out_pos]))
        else flag_error($sformatf("dout %0d at position %0d, expected %0d",
            $sampled(dout), $sampled(out_pos), exp_vec[$sampled(out_pos)]));

    a_dout_reduced: assert property (@(posedge clk) disable iff (reset)
        out_active |-> (dout < Q))
        else flag_error($sformatf("dout %0d not below the modulus", $sampled(dout)));

    a_done_one_cycle: assert property (@(posedge clk) disable iff (reset)
        done |=> !done)
        else flag_error("done held high for more than one cycle");

    a_done_per_start: assert property (@(posedge clk) disable iff (reset)
        done |-> (done_count < start_count))
        else flag_error($sformatf("done number %0d with only %0d accepted starts",
            $sampled(done_count) + 1, $sampled(start_count)));

    initial begin
        #(longint'(WATCHDOG_CYCLES) * CLK_PERIOD);
        $display("Checks failed");
        $fatal(1, "run timed out waiting for done");
    end

    initial begin
        reset     = 1'b1;
        load_w    = 1'b0;
        load_data = 1'b0;
        start     = 1'b0;
        din       = '0;
        void'($urandom(14));
        root = find_root();
        for (int i = 0; i < HALF_SIZE; i++) begin
            tw_vec[i] = coef_t'(mod_pow(root, i));
        end
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;

        load_twiddles();
        // later loads reuse the stored twiddles
        for (int r = 0; r < 3; r++) begin
            for (int i = 0; i < RING_SIZE; i++) begin
                coef_vec[i] = coef_t'($urandom % MOD);
            end
            load_coefs();
            run_transform(1'b0);
        end

        for (int i = 0; i < RING_SIZE; i++) begin
            coef_vec[i] = (i == 0) ? coef_t'(1) : '0;
        end
        load_coefs();
        run_transform(1'b0);

        for (int i = 0; i < RING_SIZE; i++) begin
            coef_vec[i] = '0;
        end
        load_coefs();
        run_transform(1'b0);

        for (int i = 0; i < RING_SIZE; i++) begin
            coef_vec[i] = coef_t'($urandom % MOD);
        end
        load_coefs();
        run_transform(1'b1);

        // catch a late extra done
        repeat (2 * PIPE_DELAY) @(posedge clk);
        $display("All checks passed");
        $finish;
    end

endmodule

//--- verilog/addr_gen.sv
// stage and butterfly scheduler with delayed write-back and drain waits
`timescale 1ns/1ps

module addr_gen (
    input  logic        clk,
    input  logic        reset,
    input  logic        start,
    ntt_sched_if.sched  sched
);
    import ntt_pkg::*;

    logic                          active;
    logic                          issuing;
    logic                          finished_q;
    logic [$clog2(RING_DEPTH)-1:0] stage;
    logic [TW_ADDR_W-1:0]          bfly;
    logic [$clog2(PIPE_DELAY)-1:0] drain;
    addr_t                         half;
    addr_t                         mask;
    addr_t                         j_ext;
    addr_t                         a_addr;
    addr_t                         b_addr;
    tw_addr_t                      tw;
    logic [PIPE_DELAY-1:0]         wb_valid;
    addr_t                         wb_addr_a [PIPE_DELAY];
    addr_t                         wb_addr_b [PIPE_DELAY];

    // butterfly j of stage s: a = group base + t, b = a + half
    always_comb begin
        half   = addr_t'(HALF_SIZE >> stage);
        mask   = half - 1'b1;
        j_ext  = addr_t'(bfly);
        a_addr = ((j_ext & ~mask) << 1) | (j_ext & mask);
        b_addr = a_addr | half;
        tw     = tw_addr_t'((j_ext & mask) << stage);
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            active     <= 1'b0;
            issuing    <= 1'b0;
            finished_q <= 1'b0;
            stage      <= '0;
            bfly       <= '0;
            drain      <= '0;
        end else begin
            finished_q <= 1'b0;
            if (!active) begin
                if (start) begin
                    active  <= 1'b1;
                    issuing <= 1'b1;
                    stage   <= '0;
                    bfly    <= '0;
                end
            end else if (issuing) begin
                bfly <= bfly + 1'b1;
                if (bfly == tw_addr_t'(HALF_SIZE - 1)) begin
                    issuing <= 1'b0;
                    drain   <= '0;
                end
            end else begin
                // let the last write of the stage land
                drain <= drain + 1'b1;
                if (drain == ($clog2(PIPE_DELAY))'(PIPE_DELAY - 1)) begin
                    if (stage == ($clog2(RING_DEPTH))'(RING_DEPTH - 1)) begin
                        active     <= 1'b0;
                        finished_q <= 1'b1;
                    end else begin
                        stage   <= stage + 1'b1;
                        issuing <= 1'b1;
                        bfly    <= '0;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wb_valid <= '0;
        end else begin
            wb_valid <= {wb_valid[PIPE_DELAY-2:0], issuing};
        end
    end

    // write addresses follow the data through the pipeline
    always_ff @(posedge clk) begin
        wb_addr_a[0] <= a_addr;
        wb_addr_b[0] <= b_addr;
        for (int i = 1; i < PIPE_DELAY; i++) begin
            wb_addr_a[i] <= wb_addr_a[i-1];
            wb_addr_b[i] <= wb_addr_b[i-1];
        end
    end

    assign sched.rd_addr_a = issuing ? a_addr : '0;
    assign sched.rd_addr_b = issuing ? b_addr : '0;
    assign sched.tw_addr   = issuing ? tw : '0;
    assign sched.wr_addr_a = wb_addr_a[PIPE_DELAY-1];
    assign sched.wr_addr_b = wb_addr_b[PIPE_DELAY-1];
    assign sched.wr_en     = wb_valid[PIPE_DELAY-1];
    assign sched.finished  = finished_q;

    // a new stage reads only after every write of the previous one has landed
    a_drained_before_stage: assert property (@(posedge clk) disable iff (reset)
        (issuing && bfly == '0) |-> (wb_valid == '0))
        else $error("stage started with %0d write-backs in flight", $countones(wb_valid));

endmodule

//--- verilog/butterfly_unit.sv
// dif butterfly, modular add and subtract then twiddle multiply on the difference
`timescale 1ns/1ps

module butterfly_unit (
    input  logic           clk,
    input  logic           reset,
    input  ntt_pkg::coef_t a,
    input  ntt_pkg::coef_t b,
    input  ntt_pkg::coef_t w,
    output ntt_pkg::coef_t sum,
    output ntt_pkg::coef_t diff
);
    import ntt_pkg::*;

    logic [DATA_W:0] add_raw;
    coef_t           add_mod;
    coef_t           sub_mod;
    coef_t           sum_s1;
    coef_t           diff_s1;
    coef_t           w_s1;
    coef_t           sum_dly [MULT_DELAY];

    always_comb begin
        add_raw = {1'b0, a} + {1'b0, b};
        add_mod = (add_raw >= {1'b0, Q}) ? coef_t'(add_raw - {1'b0, Q}) : coef_t'(add_raw);
        // wraps in DATA_W bits, true value is below Q
        sub_mod = (a >= b) ? coef_t'(a - b) : coef_t'(a + Q - b);
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            sum_s1  <= '0;
            diff_s1 <= '0;
            w_s1    <= '0;
            for (int i = 0; i < MULT_DELAY; i++) begin
                sum_dly[i] <= '0;
            end
        end else begin
            sum_s1  <= add_mod;
            diff_s1 <= sub_mod;
            w_s1    <= w;
            // sum waits for the multiplier, total BFLY_DELAY
            sum_dly[0] <= sum_s1;
            for (int i = 1; i < MULT_DELAY; i++) begin
                sum_dly[i] <= sum_dly[i-1];
            end
        end
    end

    mod_mult mult_i (
        .clk  (clk),
        .reset(reset),
        .a    (diff_s1),
        .b    (w_s1),
        .p    (diff)
    );

    assign sum = sum_dly[MULT_DELAY-1];

endmodule

//--- verilog/coef_regfile.sv
// coefficient store with two registered reads and two writes for in-place butterflies
`timescale 1ns/1ps

module coef_regfile (
    input  logic           clk,
    input  ntt_pkg::addr_t rd_addr_a,
    input  ntt_pkg::addr_t rd_addr_b,
    output ntt_pkg::coef_t rd_data_a,
    output ntt_pkg::coef_t rd_data_b,
    input  logic           wr_en_a,
    input  logic           wr_en_b,
    input  ntt_pkg::addr_t wr_addr_a,
    input  ntt_pkg::addr_t wr_addr_b,
    input  ntt_pkg::coef_t wr_data_a,
    input  ntt_pkg::coef_t wr_data_b
);
    import ntt_pkg::*;

    coef_t mem [RING_SIZE];

    always_ff @(posedge clk) begin
        if (wr_en_a) begin
            mem[wr_addr_a] <= wr_data_a;
        end
        if (wr_en_b) begin
            mem[wr_addr_b] <= wr_data_b;
        end
        // old data on a same-cycle read and write
        rd_data_a <= mem[rd_addr_a];
        rd_data_b <= mem[rd_addr_b];
    end

    // a and b halves of a butterfly are always distinct
    a_no_write_clash: assert property (@(posedge clk)
        (wr_en_a && wr_en_b) |-> (wr_addr_a != wr_addr_b))
        else $error("both write ports hit address %0d", wr_addr_a);

endmodule

//--- verilog/mod_mult.sv
// three-stage modular multiplier with barrett reduction by the fixed prime
`timescale 1ns/1ps

module mod_mult (
    input  logic           clk,
    input  logic           reset,
    input  ntt_pkg::coef_t a,
    input  ntt_pkg::coef_t b,
    output ntt_pkg::coef_t p
);
    import ntt_pkg::*;

    logic [2*DATA_W-1:0] prod_s1;
    logic [2*DATA_W-1:0] prod_s2;
    logic [DATA_W:0]     quot_s2;
    logic [3*DATA_W:0]   prod_m;
    logic [DATA_W:0]     quot_est;
    logic [DATA_W:0]     rem;

    always_comb begin
        // quotient estimate, at most one below the true quotient
        prod_m   = prod_s1 * BARRETT_M;
        quot_est = (DATA_W+1)'(prod_m >> BARRETT_K);
        // remainder lands in [0, 2Q)
        rem      = (DATA_W+1)'(prod_s2 - quot_s2 * Q);
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            prod_s1 <= '0;
            prod_s2 <= '0;
            quot_s2 <= '0;
            p       <= '0;
        end else begin
            // stage 1: full product
            prod_s1 <= a * b;
            // stage 2: barrett quotient
            prod_s2 <= prod_s1;
            quot_s2 <= quot_est;
            // stage 3: subtract and correct once
            if (rem >= {1'b0, Q}) begin
                p <= coef_t'(rem - {1'b0, Q});
            end else begin
                p <= coef_t'(rem);
            end
        end
    end

    a_reduced: assert property (@(posedge clk) disable iff (reset) p < Q)
        else $error("product %0d not reduced", p);

endmodule

//--- verilog/ntt_core.sv
// 16-point forward ntt core, load, compute and bit-reversed output sequencing
`timescale 1ns/1ps

module ntt_core (
    input  logic           clk,
    input  logic           reset,
    input  logic           load_w,
    input  logic           load_data,
    input  logic           start,
    input  ntt_pkg::coef_t din,
    output logic           done,
    output ntt_pkg::coef_t dout
);
    import ntt_pkg::*;

    core_state_t state;
    addr_t       seq;
    logic        start_ok;
    logic        out_rd_q;

    addr_t       rf_rd_addr_a;
    coef_t       rf_rd_data_a;
    coef_t       rf_rd_data_b;
    logic        rf_wr_en_a;
    logic        rf_wr_en_b;
    addr_t       rf_wr_addr_a;
    coef_t       rf_wr_data_a;
    coef_t       tw_rd_data;
    coef_t       bf_sum;
    coef_t       bf_diff;

    ntt_sched_if sched_bus ();

    // same priority as the state machine below
    assign start_ok = (state == IDLE) && start && !load_w && !load_data;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= IDLE;
            seq   <= '0;
        end else begin
            case (state)
                IDLE: begin
                    seq <= '0;
                    if (load_w) begin
                        state <= LOAD_TW;
                    end else if (load_data) begin
                        state <= LOAD_DATA;
                    end else if (start) begin
                        state <= COMPUTE;
                    end
                end
                LOAD_TW: begin
                    seq <= seq + 1'b1;
                    if (seq == addr_t'(HALF_SIZE - 1)) begin
                        state <= IDLE;
                        seq   <= '0;
                    end
                end
                LOAD_DATA: begin
                    seq <= seq + 1'b1;
                    if (seq == addr_t'(RING_SIZE - 1)) begin
                        state <= IDLE;
                        seq   <= '0;
                    end
                end
                COMPUTE: begin
                    // position 0 is read in the finishing cycle
                    if (sched_bus.finished) begin
                        state <= OUTPUT;
                        seq   <= addr_t'(1);
                    end
                end
                OUTPUT: begin
                    seq <= seq + 1'b1;
                    if (seq == addr_t'(RING_SIZE - 1)) begin
                        state <= IDLE;
                        seq   <= '0;
                    end
                end
                default: begin
                    state <= IDLE;
                    seq   <= '0;
                end
            endcase
        end
    end

    // the scheduler parks its read address at 0 when idle
    assign rf_rd_addr_a = (state == OUTPUT) ? seq : sched_bus.rd_addr_a;
    assign rf_wr_en_a   = (state == LOAD_DATA) || ((state == COMPUTE) && sched_bus.wr_en);
    assign rf_wr_en_b   = (state == COMPUTE) && sched_bus.wr_en;
    assign rf_wr_addr_a = (state == LOAD_DATA) ? seq : sched_bus.wr_addr_a;
    assign rf_wr_data_a = (state == LOAD_DATA) ? din : bf_sum;

    // done and dout account for the registered read
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            done     <= 1'b0;
            dout     <= '0;
            out_rd_q <= 1'b0;
        end else begin
            done     <= (state == COMPUTE) && sched_bus.finished;
            out_rd_q <= ((state == COMPUTE) && sched_bus.finished) || (state == OUTPUT);
            dout     <= out_rd_q ? rf_rd_data_a : '0;
        end
    end

    addr_gen ag_i (
        .clk  (clk),
        .reset(reset),
        .start(start_ok),
        .sched(sched_bus.sched)
    );

    coef_regfile rf_i (
        .clk      (clk),
        .rd_addr_a(rf_rd_addr_a),
        .rd_addr_b(sched_bus.rd_addr_b),
        .rd_data_a(rf_rd_data_a),
        .rd_data_b(rf_rd_data_b),
        .wr_en_a  (rf_wr_en_a),
        .wr_en_b  (rf_wr_en_b),
        .wr_addr_a(rf_wr_addr_a),
        .wr_addr_b(sched_bus.wr_addr_b),
        .wr_data_a(rf_wr_data_a),
        .wr_data_b(bf_diff)
    );

    twiddle_ram tw_i (
        .clk    (clk),
        .wr_en  (state == LOAD_TW),
        .wr_addr(seq[TW_ADDR_W-1:0]),
        .wr_data(din),
        .rd_addr(sched_bus.tw_addr),
        .rd_data(tw_rd_data)
    );

    butterfly_unit bf_i (
        .clk  (clk),
        .reset(reset),
        .a    (rf_rd_data_a),
        .b    (rf_rd_data_b),
        .w    (tw_rd_data),
        .sum  (bf_sum),
        .diff (bf_diff)
    );

    // command pulses are exclusive when the core can take them
    a_one_command: assert property (@(posedge clk) disable iff (reset)
        (state == IDLE) |-> $onehot0({load_w, load_data, start}))
        else $error("more than one command pulse in IDLE");

endmodule

//--- verilog/ntt_pkg.sv
// ntt package with ring, modulus, barrett and pipeline constants and shared types
package ntt_pkg;

    // ring
    localparam int RING_SIZE  = 16;
    localparam int RING_DEPTH = 4;
    localparam int HALF_SIZE  = RING_SIZE / 2;

    // widths
    localparam int DATA_W    = 14;
    localparam int ADDR_W    = $clog2(RING_SIZE);
    localparam int TW_ADDR_W = $clog2(HALF_SIZE);

    // prime modulus and its barrett constants
    localparam logic [DATA_W-1:0] Q = 14'd12289;
    localparam int BARRETT_K = 2 * DATA_W;
    localparam logic [DATA_W:0] BARRETT_M = (DATA_W+1)'((64'd1 << BARRETT_K) / Q);

    // latencies in clock cycles
    localparam int MULT_DELAY = 3;
    localparam int BFLY_DELAY = 1 + MULT_DELAY;
    // read register plus butterfly
    localparam int PIPE_DELAY = 1 + BFLY_DELAY;

    typedef logic [DATA_W-1:0]    coef_t;
    typedef logic [ADDR_W-1:0]    addr_t;
    typedef logic [TW_ADDR_W-1:0] tw_addr_t;

    typedef enum logic [2:0] {
        IDLE,
        LOAD_TW,
        LOAD_DATA,
        COMPUTE,
        OUTPUT
    } core_state_t;

endpackage

//--- verilog/ntt_sched_if.sv
// butterfly schedule bus from the address generator to the core
`timescale 1ns/1ps

interface ntt_sched_if;
    import ntt_pkg::*;

    // butterfly being issued this cycle
    addr_t    rd_addr_a;
    addr_t    rd_addr_b;
    tw_addr_t tw_addr;

    // write-back of the butterfly issued PIPE_DELAY cycles ago
    addr_t    wr_addr_a;
    addr_t    wr_addr_b;
    logic     wr_en;

    logic     finished;

    modport sched (
        output rd_addr_a, rd_addr_b, tw_addr, wr_addr_a, wr_addr_b, wr_en, finished
    );

    modport core (
        input rd_addr_a, rd_addr_b, tw_addr, wr_addr_a, wr_addr_b, wr_en, finished
    );
endinterface

//--- verilog/twiddle_ram.sv
// twiddle factor memory, one write port and one registered read port
`timescale 1ns/1ps

module twiddle_ram (
    input  logic              clk,
    input  logic              wr_en,
    input  ntt_pkg::tw_addr_t wr_addr,
    input  ntt_pkg::coef_t    wr_data,
    input  ntt_pkg::tw_addr_t rd_addr,
    output ntt_pkg::coef_t    rd_data
);
    import ntt_pkg::*;

    // w^0 .. w^(N/2-1), kept until the next twiddle load
    coef_t mem [HALF_SIZE];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
        rd_data <= mem[rd_addr];
    end

endmodule
